/* design/decode_buffer.sv */
/*
 * Decode buffer
 * One-slot register stage toward the decoder, optional bypass,
 * cleared by an external redirect
 */
`include "fetch_macros.svh"

module decode_buffer (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load,
   input  logic [fetch_pkg::INSN_W-1:0] item_insn,
   input  logic [fetch_pkg::PC_W-1:0]   item_pc,
   input  fetch_pkg::opcode_t           item_op,
   input  logic                         item_pred_taken,
   input  logic [fetch_pkg::PC_W-1:0]   item_alt_target,
   input  logic                         item_irq,
   input  logic                         redirect_valid,
   input  logic                         out_ready,
   output logic                         space,
   output logic                         out_valid,
   output logic [fetch_pkg::INSN_W-1:0] out_insn,
   output logic [fetch_pkg::PC_W-1:0]   out_pc,
   output fetch_pkg::opcode_t           out_op,
   output logic                         out_pred_taken,
   output logic [fetch_pkg::PC_W-1:0]   out_alt_target,
   output logic                         out_irq
);

   localparam bit BYPASS = (`FETCH_BYPASS != 0);

   logic leaving;

   assign leaving = out_valid && out_ready;

   // Free when empty, or also when the item leaves this cycle
   assign space = BYPASS ? (!out_valid || leaving) : !out_valid;

   always_ff @(posedge clk) begin
      if (!rst_n)
         out_valid <= 1'b0;
      else if (redirect_valid)
         out_valid <= 1'b0;
      else if (load)
         out_valid <= 1'b1;
      else if (leaving)
         out_valid <= 1'b0;
   end

   // Payload
   always_ff @(posedge clk) begin
      if (load) begin
         out_insn       <= item_insn;
         out_pc         <= item_pc;
         out_op         <= item_op;
         out_pred_taken <= item_pred_taken;
         out_alt_target <= item_alt_target;
         out_irq        <= item_irq;
      end
   end

endmodule

/* design/fetch_if.sv */
/*
 * Fetched word channel from the bus requester to the predecoder
 * Valid/ready handshake with instruction and word address
 */
interface fetch_if;

   logic                        valid;
   logic                        ready;
   logic [fetch_pkg::INSN_W-1:0] insn;
   // Word address of insn
   logic [fetch_pkg::PC_W-1:0]   pc;

   modport requester (
      output valid,
      output insn,
      output pc,
      input  ready
   );

   modport predecoder (
      input  valid,
      input  insn,
      input  pc,
      output ready
   );

endinterface

/* design/fetch_macros.svh */
/*
 * Fetch stage configuration values
 * Address and instruction widths, entry vectors (word addresses),
 * decode buffer bypass option and relative offset width
 */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Byte address width, program counters drop the two low bits
`define FETCH_AW 32

// Instruction word width
`define FETCH_IW 32

// Entry points as word addresses
`define FETCH_RESET_VECT   30'h0000_0040
`define FETCH_SYSCALL_VECT 30'h0000_0080
`define FETCH_IRQ_VECT     30'h0000_00C0

// 1 lets the buffer refill in the cycle its item leaves
`define FETCH_BYPASS 1

// Signed word offset in the low instruction bits
`define FETCH_OFS_W 26

`endif

/* design/fetch_pkg.sv */
/*
 * Fetch stage shared types
 * Field widths of a fetched item, opcode enum and its decode function,
 * bus requester state enum
 */
`include "fetch_macros.svh"

package fetch_pkg;

   // Fetched item field widths
   localparam int PC_W   = `FETCH_AW - 2;
   localparam int INSN_W = `FETCH_IW;
   localparam int OP_W   = 6;
   localparam int OFS_W  = `FETCH_OFS_W;

   // Top six instruction bits
   typedef enum logic [OP_W-1:0] {
      OP_SEQ     = 6'h00,
      OP_JMPREL  = 6'h01,
      OP_BCC     = 6'h02,
      OP_SYSCALL = 6'h03
   } opcode_t;

   // Bus requester states
   typedef enum logic [1:0] {
      ST_RESET,
      ST_RUN,
      ST_FLUSH
   } fetch_state_t;

   // Unknown codes fall back to a sequential instruction
   function automatic opcode_t to_opcode(input logic [OP_W-1:0] code);
      case (code)
         OP_JMPREL,
         OP_BCC,
         OP_SYSCALL: to_opcode = opcode_t'(code);
         default:    to_opcode = OP_SEQ;
      endcase
   endfunction

endpackage

/* design/fetch_predecoder.sv */
/*
 * Fetch predecoder
 * Opcode and offset decode, static backward-taken prediction,
 * interrupt marking and redirect generation toward the requester
 */
`include "fetch_macros.svh"

module fetch_predecoder (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         irq_req,
   input  logic                         redirect_valid,
   input  logic                         space,
   fetch_if.predecoder                  fe,
   output logic                         pd_redirect,
   output logic [fetch_pkg::PC_W-1:0]   pd_target,
   output logic                         load,
   output logic [fetch_pkg::INSN_W-1:0] item_insn,
   output logic [fetch_pkg::PC_W-1:0]   item_pc,
   output fetch_pkg::opcode_t           item_op,
   output logic                         item_pred_taken,
   output logic [fetch_pkg::PC_W-1:0]   item_alt_target,
   output logic                         item_irq
);

   import fetch_pkg::*;

   opcode_t          op;
   logic             ofs_neg;
   logic [PC_W-1:0]  ofs_ext;
   logic [PC_W-1:0]  rel_target;
   logic [PC_W-1:0]  seq_target;
   logic             move;
   logic             irq_now;
   logic             irq_taken;
   logic             is_jmp;
   logic             is_sys;
   logic             is_bcc;

   assign fe.ready = space;
   assign move     = fe.valid && fe.ready;

   assign op         = to_opcode(fe.insn[INSN_W-1 -: OP_W]);
   assign ofs_neg    = fe.insn[OFS_W-1];
   assign ofs_ext    = {{(PC_W-OFS_W){ofs_neg}}, fe.insn[OFS_W-1:0]};
   assign rel_target = fe.pc + ofs_ext;
   assign seq_target = fe.pc + 1'b1;

   // One marked item per irq_req level
   assign irq_now = irq_req && !irq_taken;

   assign is_sys = (op == OP_SYSCALL);
   assign is_jmp = (op == OP_JMPREL);
   assign is_bcc = (op == OP_BCC);

   // Same-cycle external redirect cancels the word
   assign load = move && !redirect_valid;

   assign pd_redirect = load && (irq_now || is_sys || is_jmp || (is_bcc && ofs_neg));

   always_comb begin
      if (irq_now)
         pd_target = `FETCH_IRQ_VECT;
      else if (is_sys)
         pd_target = `FETCH_SYSCALL_VECT;
      else
         pd_target = rel_target;
   end

   // Interrupt item carries only its pc
   assign item_irq        = irq_now;
   assign item_pc         = fe.pc;
   assign item_insn       = irq_now ? '0 : fe.insn;
   assign item_op         = irq_now ? OP_SEQ : op;
   assign item_pred_taken = !irq_now && is_bcc && ofs_neg;

   // Path not followed by the prediction, zero for non-branches
   always_comb begin
      if (irq_now || !is_bcc)
         item_alt_target = '0;
      else if (ofs_neg)
         item_alt_target = seq_target;
      else
         item_alt_target = rel_target;
   end

   // Cleared once the source drops irq_req, or when the buffer is flushed
   always_ff @(posedge clk) begin
      if (!rst_n)
         irq_taken <= 1'b0;
      else
         irq_taken <= irq_req && !redirect_valid && (irq_taken || (load && irq_now));
   end

endmodule

/* design/fetch_unit_top.sv */
/*
 * Instruction fetch unit top level
 * Bus requester, predecoder and decode buffer joined by fetch_if
 */
`include "fetch_macros.svh"

module fetch_unit_top (
   input  logic                         clk,
   input  logic                         rst_n,
   output logic                         ibus_cmd_valid,
   output logic [`FETCH_AW-1:0]         ibus_cmd_addr,
   input  logic                         ibus_cmd_ready,
   input  logic                         ibus_rsp_valid,
   input  logic [fetch_pkg::INSN_W-1:0] ibus_rsp_data,
   input  logic [`FETCH_AW-1:0]         ibus_rsp_addr,
   output logic                         ibus_rsp_ready,
   output logic                         ibus_flush_req,
   input  logic                         ibus_flush_ack,
   input  logic                         redirect_valid,
   input  logic [fetch_pkg::PC_W-1:0]   redirect_target,
   input  logic                         irq_req,
   output logic                         out_valid,
   output logic [fetch_pkg::INSN_W-1:0] out_insn,
   output logic [fetch_pkg::PC_W-1:0]   out_pc,
   output fetch_pkg::opcode_t           out_op,
   output logic                         out_pred_taken,
   output logic [fetch_pkg::PC_W-1:0]   out_alt_target,
   output logic                         out_irq,
   input  logic                         out_ready
);

   import fetch_pkg::*;

   fetch_if fe ();

   logic               pd_redirect;
   logic [PC_W-1:0]    pd_target;
   logic               load;
   logic               space;
   logic [INSN_W-1:0]  item_insn;
   logic [PC_W-1:0]    item_pc;
   opcode_t            item_op;
   logic               item_pred_taken;
   logic [PC_W-1:0]    item_alt_target;
   logic               item_irq;

   ibus_requester u_req (
      .clk             (clk),
      .rst_n           (rst_n),
      .ibus_cmd_valid  (ibus_cmd_valid),
      .ibus_cmd_addr   (ibus_cmd_addr),
      .ibus_cmd_ready  (ibus_cmd_ready),
      .ibus_rsp_valid  (ibus_rsp_valid),
      .ibus_rsp_data   (ibus_rsp_data),
      .ibus_rsp_addr   (ibus_rsp_addr),
      .ibus_rsp_ready  (ibus_rsp_ready),
      .ibus_flush_req  (ibus_flush_req),
      .ibus_flush_ack  (ibus_flush_ack),
      .redirect_valid  (redirect_valid),
      .redirect_target (redirect_target),
      .pd_redirect     (pd_redirect),
      .pd_target       (pd_target),
      .fe              (fe.requester)
   );

   fetch_predecoder u_pd (
      .clk             (clk),
      .rst_n           (rst_n),
      .irq_req         (irq_req),
      .redirect_valid  (redirect_valid),
      .space           (space),
      .fe              (fe.predecoder),
      .pd_redirect     (pd_redirect),
      .pd_target       (pd_target),
      .load            (load),
      .item_insn       (item_insn),
      .item_pc         (item_pc),
      .item_op         (item_op),
      .item_pred_taken (item_pred_taken),
      .item_alt_target (item_alt_target),
      .item_irq        (item_irq)
   );

   decode_buffer u_buf (
      .clk             (clk),
      .rst_n           (rst_n),
      .load            (load),
      .item_insn       (item_insn),
      .item_pc         (item_pc),
      .item_op         (item_op),
      .item_pred_taken (item_pred_taken),
      .item_alt_target (item_alt_target),
      .item_irq        (item_irq),
      .redirect_valid  (redirect_valid),
      .out_ready       (out_ready),
      .space           (space),
      .out_valid       (out_valid),
      .out_insn        (out_insn),
      .out_pc          (out_pc),
      .out_op          (out_op),
      .out_pred_taken  (out_pred_taken),
      .out_alt_target  (out_alt_target),
      .out_irq         (out_irq)
   );

endmodule

/* design/ibus_requester.sv */
/*
 * Instruction bus requester
 * Fetch pc, start-up delay, sequential command issue with an
 * outstanding limit, flush handshake and response forwarding
 */
`include "fetch_macros.svh"

module ibus_requester (
   input  logic                         clk,
   input  logic                         rst_n,
   output logic                         ibus_cmd_valid,
   output logic [`FETCH_AW-1:0]         ibus_cmd_addr,
   input  logic                         ibus_cmd_ready,
   input  logic                         ibus_rsp_valid,
   input  logic [fetch_pkg::INSN_W-1:0] ibus_rsp_data,
   input  logic [`FETCH_AW-1:0]         ibus_rsp_addr,
   output logic                         ibus_rsp_ready,
   output logic                         ibus_flush_req,
   input  logic                         ibus_flush_ack,
   input  logic                         redirect_valid,
   input  logic [fetch_pkg::PC_W-1:0]   redirect_target,
   input  logic                         pd_redirect,
   input  logic [fetch_pkg::PC_W-1:0]   pd_target,
   fetch_if.requester                   fe
);

   import fetch_pkg::*;

   localparam logic [2:0] START_LAST = 3'd2;
   localparam logic [2:0] MAX_OUT    = 3'd4;

   fetch_state_t    state;
   logic [2:0]      start_cnt;
   logic [2:0]      out_cnt;
   logic [PC_W-1:0] cmd_pc;

   logic            cmd_fire;
   logic            rsp_fire;
   logic            redirect_any;
   logic [PC_W-1:0] redirect_pc;

   assign ibus_cmd_valid = (state == ST_RUN) && (out_cnt != MAX_OUT);
   assign ibus_cmd_addr  = {cmd_pc, 2'b00};
   assign ibus_flush_req = (state == ST_FLUSH);

   // Stale responses are drained while flushing
   assign ibus_rsp_ready = (state == ST_FLUSH) || ((state == ST_RUN) && fe.ready);

   assign cmd_fire = ibus_cmd_valid && ibus_cmd_ready;
   assign rsp_fire = ibus_rsp_valid && ibus_rsp_ready;

   assign fe.valid = (state == ST_RUN) && ibus_rsp_valid;
   assign fe.insn  = ibus_rsp_data;
   assign fe.pc    = ibus_rsp_addr[`FETCH_AW-1:2];

   // External redirect wins over the predecoder
   assign redirect_any = redirect_valid || pd_redirect;
   assign redirect_pc  = redirect_valid ? redirect_target : pd_target;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= ST_RESET;
         start_cnt <= 3'd0;
         cmd_pc    <= `FETCH_RESET_VECT;
      end else begin
         case (state)
            ST_RESET: begin
               start_cnt <= start_cnt + 3'd1;
               if (redirect_valid)
                  cmd_pc <= redirect_target;
               if (start_cnt == START_LAST)
                  state <= ST_RUN;
            end
            ST_RUN: begin
               if (redirect_any) begin
                  state  <= ST_FLUSH;
                  cmd_pc <= redirect_pc;
               end else if (cmd_fire) begin
                  cmd_pc <= cmd_pc + 1'b1;
               end
            end
            ST_FLUSH: begin
               // A new external redirect restarts the flush with its target
               if (redirect_valid)
                  cmd_pc <= redirect_target;
               else if (ibus_flush_ack)
                  state <= ST_RUN;
            end
            default: state <= ST_RESET;
         endcase
      end
   end

   // Commands in flight; the flush ack retires all of them
   always_ff @(posedge clk) begin
      if (!rst_n)
         out_cnt <= 3'd0;
      else if ((state == ST_FLUSH) && ibus_flush_ack)
         out_cnt <= 3'd0;
      else
         out_cnt <= out_cnt + {2'b00, cmd_fire} - {2'b00, rsp_fire};
   end

endmodule

/* files.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_if.sv
design/ibus_requester.sv
design/fetch_predecoder.sv
design/decode_buffer.sv
design/fetch_unit_top.sv
verification/ibus_mem_model.sv
verification/tb_fetch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fetch_unit -f files.f
./obj_dir/Vtb_fetch_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

/* verification/ibus_mem_model.sv */
/*
 * Instruction memory responder for the fetch unit testbench
 * 256-word random table, in-order responses with 1 to 4 cycles latency,
 * up to 4 queued commands, random cmd_ready, flush ack after 1 to 3 cycles
 */
module ibus_mem_model #(
   parameter int SEED = 84063
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cmd_valid,
   input  logic [31:0] cmd_addr,
   output logic        cmd_ready,
   output logic        rsp_valid,
   output logic [31:0] rsp_data,
   output logic [31:0] rsp_addr,
   input  logic        rsp_ready,
   input  logic        flush_req,
   output logic        flush_ack
);

   logic [31:0] words [0:255];
   logic [29:0] q_addr [$];
   int          q_due [$];
   int          seed;
   int          now;
   int          ack_wait;
   logic        ack_fire;

   // Table contents, a mix of sequential words, jumps, branches and system calls
   initial begin
      logic [31:0] r;
      logic [31:0] r2;
      logic [25:0] ofs;
      logic [5:0]  code;
      seed = SEED;
      for (int i = 0; i < 256; i++) begin
         r   = $random(seed);
         r2  = $random(seed);
         ofs = 26'(r2[2:0]) + 26'd1;
         if (r2[3])
            ofs = -ofs;
         case (r[3:0])
            4'd0, 4'd1:       code = 6'h01;
            4'd2, 4'd3, 4'd4: code = 6'h02;
            4'd5:             code = 6'h03;
            default: begin
               code = {1'b1, r[8:4]};
               ofs  = r2[31:6];
            end
         endcase
         words[i] = {code, ofs};
      end
      cmd_ready = 1'b0;
      rsp_valid = 1'b0;
      rsp_data  = '0;
      rsp_addr  = '0;
      flush_ack = 1'b0;
   end

   always @(posedge clk) begin
      ack_fire = 1'b0;
      if (!rst_n) begin
         q_addr.delete();
         q_due.delete();
         now      = 0;
         ack_wait = 0;
      end else begin
         now++;
         if (rsp_valid && rsp_ready) begin
            void'(q_addr.pop_front());
            void'(q_due.pop_front());
         end
         if (cmd_valid && cmd_ready) begin
            q_addr.push_back(cmd_addr[31:2]);
            q_due.push_back(now + 1 + int'($random(seed) & 3));
         end
         // Drop everything in flight, then acknowledge
         if (flush_req && !flush_ack) begin
            q_addr.delete();
            q_due.delete();
            if (ack_wait == 0) begin
               ack_wait = 1 + int'(($random(seed) & 32'h7fff) % 3);
            end else begin
               ack_wait--;
               ack_fire = (ack_wait == 0);
            end
         end
      end
      #10;
      flush_ack = ack_fire;
      rsp_valid = (q_addr.size() > 0) && (q_due[0] <= now);
      rsp_addr  = (q_addr.size() > 0) ? {q_addr[0], 2'b00} : '0;
      rsp_data  = (q_addr.size() > 0) ? words[q_addr[0][7:0]] : '0;
      cmd_ready = rst_n && (q_addr.size() < 4) && (($random(seed) & 3) != 0);
   end

endmodule

/* verification/tb_fetch_unit.sv */
/*
 * Fetch unit testbench
 * Clock, reset, random redirects, interrupts and back-pressure,
 * reference model of the expected pc stream, start-up and flush timing,
 * compare task and timeout
 */
`include "fetch_macros.svh"

module tb_fetch_unit;

   import fetch_pkg::*;

   localparam int NUM_ITEMS   = 3000;
   localparam int CYCLE_LIMIT = NUM_ITEMS * 20;

   logic        clk;
   logic        rst_n;
   logic        ibus_cmd_valid;
   logic [31:0] ibus_cmd_addr;
   logic        ibus_cmd_ready;
   logic        ibus_rsp_valid;
   logic [31:0] ibus_rsp_data;
   logic [31:0] ibus_rsp_addr;
   logic        ibus_rsp_ready;
   logic        ibus_flush_req;
   logic        ibus_flush_ack;
   logic        redirect_valid;
   logic [29:0] redirect_target;
   logic        irq_req;
   logic        out_valid;
   logic [31:0] out_insn;
   logic [29:0] out_pc;
   opcode_t     out_op;
   logic        out_pred_taken;
   logic [29:0] out_alt_target;
   logic        out_irq;
   logic        out_ready;

   int          seed;
   int          cycle;
   int          delivered;
   int          plain_in_irq;
   logic [29:0] exp_pc;
   logic        irq_seen;
   logic        redirect_prev;
   logic        held;
   logic [29:0] held_pc;
   logic [31:0] held_insn;

   fetch_unit_top uut (.*);

   ibus_mem_model #(.SEED(84063)) mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (ibus_cmd_valid),
      .cmd_addr  (ibus_cmd_addr),
      .cmd_ready (ibus_cmd_ready),
      .rsp_valid (ibus_rsp_valid),
      .rsp_data  (ibus_rsp_data),
      .rsp_addr  (ibus_rsp_addr),
      .rsp_ready (ibus_rsp_ready),
      .flush_req (ibus_flush_req),
      .flush_ack (ibus_flush_ack)
   );

   always #50 clk = ~clk;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "mismatch");
      end
   endtask

   // Checks one delivered item and moves the expected pc on
   task automatic check_item();
      logic [31:0] w;
      logic [29:0] ofs;
      opcode_t     op;
      logic        taken;
      logic [29:0] alt;
      if (out_irq) begin
         if (!irq_req || irq_seen) begin
            $display("Interrupt item delivered at %0t without a pending interrupt", $time);
            $display("Errors found");
            $fatal(1, "unexpected interrupt item");
         end
         compare("out_pc", 32'(out_pc), 32'(exp_pc));
         compare("out_insn", out_insn, 32'd0);
         compare("out_op", 32'(out_op), 32'(OP_SEQ));
         compare("out_pred_taken", 32'(out_pred_taken), 32'd0);
         compare("out_alt_target", 32'(out_alt_target), 32'd0);
         irq_seen = 1'b1;
         exp_pc   = `FETCH_IRQ_VECT;
      end else begin
         // Only the item already buffered when irq_req rose may go out unmarked
         if (irq_req) begin
            plain_in_irq++;
            if (plain_in_irq > 1) begin
               $display("Interrupt not taken at %0t, a second plain item arrived", $time);
               $display("Errors found");
               $fatal(1, "interrupt not taken");
            end
         end
         w   = mem.words[exp_pc[7:0]];
         ofs = {{4{w[25]}}, w[25:0]};
         case (w[31:26])
            6'h01:   op = OP_JMPREL;
            6'h02:   op = OP_BCC;
            6'h03:   op = OP_SYSCALL;
            default: op = OP_SEQ;
         endcase
         // Backward branches are predicted taken
         taken = (op == OP_BCC) && w[25];
         alt   = (op != OP_BCC) ? 30'd0 : (taken ? exp_pc + 30'd1 : exp_pc + ofs);
         compare("out_pc", 32'(out_pc), 32'(exp_pc));
         compare("out_insn", out_insn, w);
         compare("out_op", 32'(out_op), 32'(op));
         compare("out_pred_taken", 32'(out_pred_taken), 32'(taken));
         compare("out_alt_target", 32'(out_alt_target), 32'(alt));
         if (op == OP_SYSCALL)
            exp_pc = `FETCH_SYSCALL_VECT;
         else if (op == OP_JMPREL || taken)
            exp_pc = exp_pc + ofs;
         else
            exp_pc = exp_pc + 30'd1;
      end
      delivered++;
   endtask

   // Reference model and timeout, sampled on the rising edge
   always @(posedge clk) begin
      if (rst_n) begin
         cycle++;
         if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d items delivered", cycle, delivered);
            $display("Errors found");
            $fatal(1, "timeout");
         end
         // Three idle cycles, then the first command at the reset entry
         if (cycle <= 3) begin
            compare("ibus_cmd_valid", 32'(ibus_cmd_valid), 32'd0);
            compare("ibus_rsp_ready", 32'(ibus_rsp_ready), 32'd0);
            compare("ibus_flush_req", 32'(ibus_flush_req), 32'd0);
            compare("out_valid", 32'(out_valid), 32'd0);
         end else if (cycle == 4) begin
            compare("ibus_cmd_valid", 32'(ibus_cmd_valid), 32'd1);
            compare("ibus_cmd_addr", ibus_cmd_addr, {`FETCH_RESET_VECT, 2'b00});
         end
         if (redirect_prev)
            compare("ibus_flush_req", 32'(ibus_flush_req), 32'd1);
         if (!irq_req)
            plain_in_irq = 0;
         if (held && out_valid) begin
            compare("held out_pc", 32'(out_pc), 32'(held_pc));
            compare("held out_insn", out_insn, held_insn);
         end
         if (out_valid && out_ready)
            check_item();
         if (redirect_valid)
            exp_pc = redirect_target;
         held          = out_valid && !out_ready && !redirect_valid;
         held_pc       = out_pc;
         held_insn     = out_insn;
         redirect_prev = redirect_valid;
      end
   end

   initial begin
      logic [31:0] r;
      seed            = 84063;
      clk             = 1'b0;
      rst_n           = 1'b0;
      redirect_valid  = 1'b0;
      redirect_target = '0;
      irq_req         = 1'b0;
      out_ready       = 1'b0;
      cycle           = 0;
      delivered       = 0;
      plain_in_irq    = 0;
      exp_pc          = `FETCH_RESET_VECT;
      irq_seen        = 1'b0;
      redirect_prev   = 1'b0;
      held            = 1'b0;
      repeat (16) @(posedge clk);
      #10;
      rst_n = 1'b1;
      while (delivered < NUM_ITEMS) begin
         @(posedge clk);
         #10;
         out_ready      = ($random(seed) & 3) != 0;
         redirect_valid = 1'b0;
         r              = $random(seed);
         if (delivered > 0 && r[5:0] == 6'd0) begin
            redirect_valid  = 1'b1;
            redirect_target = r[31:2];
         end
         // Source drops the level once its marked item has left
         if (irq_seen) begin
            irq_req  = 1'b0;
            irq_seen = 1'b0;
         end else if (!irq_req && ($random(seed) & 63) == 0) begin
            irq_req = 1'b1;
         end
      end
      $display("No errors");
      $finish;
   end

endmodule
